/* verilog/autotest_pkg.sv */
`default_nettype none

package autotest_pkg;

  // sd card side
  typedef logic [7:0] sd_byte_t;
  typedef logic [31:0] sd_addr_t;
  typedef logic [9:0] byte_count_t;

  // block header fields
  typedef logic [31:0] signature_t;
  typedef logic [79:0] uut_key_t;
  typedef logic [63:0] uut_block_t;

  localparam int BLOCK_BYTES = 512;
  localparam int HEADER_BYTES = 25;
  localparam int RESULT_BYTES = 8;
  // header and result bytes that come before the fill
  localparam int RECORD_BYTES = HEADER_BYTES + RESULT_BYTES;

  typedef logic [HEADER_BYTES-1:0][7:0] header_t;
  typedef logic [RECORD_BYTES-1:0][7:0] record_t;

  localparam signature_t SIGNATURE_OK = 32'hAABB_CCDD;
  localparam sd_addr_t BLOCK_BASE = 32'h0010_0000;
  localparam sd_byte_t FILL_BYTE = 8'hFF;

  // short enough for simulation
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int TIMER_W = $clog2(TIMEOUT_CYCLES + 1);

  typedef logic [TIMER_W-1:0] timer_t;

endpackage

`default_nettype wire

/* verilog/sd_block_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_block_reader (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  start_i,
  input  wire logic                  spi_busy_i,
  input  wire autotest_pkg::sd_byte_t spi_data_out_i,
  output logic                       spi_rst_o,
  output logic                       spi_r_block_o,
  output logic                       spi_r_byte_o,
  output logic                       hdr_valid_o,
  output autotest_pkg::sd_byte_t     hdr_byte_o,
  output logic                       done_o
);

  typedef enum logic [2:0] {
    R_IDLE,
    R_RST,
    R_RST_WAIT,
    R_OPEN,
    R_OPEN_WAIT,
    R_BYTE,
    R_BYTE_WAIT
  } rd_state_t;

  rd_state_t state;
  autotest_pkg::byte_count_t count;
  logic byte_in;

  // byte is on the bus once busy drops
  assign byte_in = (state == R_BYTE_WAIT) && !spi_busy_i;

  assign spi_rst_o = (state == R_RST);
  assign spi_r_block_o = (state != R_IDLE) && (state != R_RST) && (state != R_RST_WAIT);
  assign spi_r_byte_o = (state == R_BYTE);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= R_IDLE;
      count <= '0;
      hdr_valid_o <= 1'b0;
      done_o <= 1'b0;
    end
    else
    begin
      hdr_valid_o <= 1'b0;
      done_o <= 1'b0;
      case (state)
        R_IDLE:
          if (start_i)
          begin
            count <= '0;
            state <= R_RST;
          end
        R_RST:
          if (spi_busy_i)
            state <= R_RST_WAIT;
        R_RST_WAIT:
          if (!spi_busy_i)
            state <= R_OPEN;
        R_OPEN:
          if (spi_busy_i)
            state <= R_OPEN_WAIT;
        R_OPEN_WAIT:
          if (!spi_busy_i)
            state <= R_BYTE;
        R_BYTE:
          if (spi_busy_i)
            state <= R_BYTE_WAIT;
        R_BYTE_WAIT:
          if (byte_in)
          begin
            // bytes past the header are only drained
            hdr_valid_o <= count < autotest_pkg::byte_count_t'(autotest_pkg::HEADER_BYTES);
            count <= count + 1'b1;
            if (count == autotest_pkg::byte_count_t'(autotest_pkg::BLOCK_BYTES - 1))
            begin
              done_o <= 1'b1;
              state <= R_IDLE;
            end
            else
              state <= R_BYTE;
          end
        default:
          state <= R_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (byte_in)
      hdr_byte_o <= spi_data_out_i;
  end

endmodule

`default_nettype wire

/* verilog/test_vector_store.sv */
`timescale 1ns/1ps
`default_nettype none

module test_vector_store (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  clear_i,
  input  wire logic                  hdr_valid_i,
  input  wire autotest_pkg::sd_byte_t hdr_byte_i,
  output autotest_pkg::signature_t   signature_o,
  output autotest_pkg::sd_byte_t     iteration_o,
  output autotest_pkg::uut_key_t     iv_o,
  output autotest_pkg::uut_key_t     key_o
);

  autotest_pkg::header_t hdr;

  // first byte in ends up at the top
  always_ff @(posedge clk)
  begin
    if (rst || clear_i)
      hdr <= '0;
    else if (hdr_valid_i)
      hdr <= {hdr[autotest_pkg::HEADER_BYTES-2:0], hdr_byte_i};
  end

  // fields split in header order
  assign {signature_o, iteration_o, iv_o, key_o} = hdr;

endmodule

`default_nettype wire

/* verilog/uut_test_runner.sv */
`timescale 1ns/1ps
`default_nettype none

module uut_test_runner (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    start_i,
  input  wire logic                    end_uut_i,
  input  wire autotest_pkg::uut_block_t block_i,
  output logic                         rst_uut_o,
  output autotest_pkg::uut_block_t     result_o,
  output logic                         done_o
);

  typedef enum logic {
    U_IDLE,
    U_RUN
  } run_state_t;

  run_state_t state;
  autotest_pkg::timer_t timer;
  logic finish;

  // uut done or given up on
  assign finish = (state == U_RUN) &&
                  (end_uut_i || timer == autotest_pkg::timer_t'(autotest_pkg::TIMEOUT_CYCLES - 1));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= U_IDLE;
      timer <= '0;
      rst_uut_o <= 1'b1;
      done_o <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state)
        U_IDLE:
          if (start_i)
          begin
            timer <= '0;
            rst_uut_o <= 1'b0;
            state <= U_RUN;
          end
        U_RUN:
          begin
            timer <= timer + 1'b1;
            if (finish)
            begin
              rst_uut_o <= 1'b1;
              done_o <= 1'b1;
              state <= U_IDLE;
            end
          end
        default:
          state <= U_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (finish)
      result_o <= block_i;
  end

endmodule

`default_nettype wire

/* verilog/sd_block_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_block_writer (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    start_i,
  input  wire logic                    spi_busy_i,
  input  wire autotest_pkg::signature_t signature_i,
  input  wire autotest_pkg::sd_byte_t   iteration_i,
  input  wire autotest_pkg::uut_key_t   iv_i,
  input  wire autotest_pkg::uut_key_t   key_i,
  input  wire autotest_pkg::uut_block_t result_i,
  output logic                         spi_w_block_o,
  output logic                         spi_w_byte_o,
  output autotest_pkg::sd_byte_t       spi_data_in_o,
  output logic                         done_o
);

  typedef enum logic [2:0] {
    W_IDLE,
    W_OPEN,
    W_OPEN_WAIT,
    W_BYTE,
    W_BYTE_WAIT
  } wr_state_t;

  wr_state_t state;
  autotest_pkg::byte_count_t count;
  autotest_pkg::record_t rec;
  autotest_pkg::uut_block_t result_le;
  logic byte_out;

  // result goes out lsb first
  assign result_le = {<<8{result_i}};

  assign byte_out = (state == W_BYTE_WAIT) && !spi_busy_i;

  assign spi_w_block_o = (state != W_IDLE);
  assign spi_w_byte_o = (state == W_BYTE);
  assign spi_data_in_o = rec[autotest_pkg::RECORD_BYTES-1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= W_IDLE;
      count <= '0;
      done_o <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state)
        W_IDLE:
          if (start_i)
          begin
            count <= '0;
            state <= W_OPEN;
          end
        W_OPEN:
          if (spi_busy_i)
            state <= W_OPEN_WAIT;
        W_OPEN_WAIT:
          if (!spi_busy_i)
            state <= W_BYTE;
        W_BYTE:
          if (spi_busy_i)
            state <= W_BYTE_WAIT;
        W_BYTE_WAIT:
          if (byte_out)
          begin
            count <= count + 1'b1;
            if (count == autotest_pkg::byte_count_t'(autotest_pkg::BLOCK_BYTES - 1))
            begin
              done_o <= 1'b1;
              state <= W_IDLE;
            end
            else
              state <= W_BYTE;
          end
        default:
          state <= W_IDLE;
      endcase
    end
  end

  // fill bytes shift in behind the record
  always_ff @(posedge clk)
  begin
    if (state == W_IDLE && start_i)
      rec <= {signature_i, iteration_i, iv_i, key_i, result_le};
    else if (byte_out)
      rec <= {rec[autotest_pkg::RECORD_BYTES-2:0], autotest_pkg::FILL_BYTE};
  end

endmodule

`default_nettype wire

/* verilog/autotest_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module autotest_ctrl (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    read_done_i,
  input  wire logic                    run_done_i,
  input  wire logic                    write_done_i,
  input  wire autotest_pkg::signature_t signature_i,
  output logic                         read_start_o,
  output logic                         run_start_o,
  output logic                         write_start_o,
  output autotest_pkg::sd_addr_t       spi_block_addr_o,
  output logic                         halted_o
);

  typedef enum logic [2:0] {
    C_READ,
    C_READ_WAIT,
    C_CHECK,
    C_RUN_WAIT,
    C_WRITE,
    C_WRITE_WAIT,
    C_HALT
  } ctrl_state_t;

  ctrl_state_t state;
  autotest_pkg::sd_addr_t blk_count;
  logic sig_ok;

  assign sig_ok = (signature_i == autotest_pkg::SIGNATURE_OK);

  assign read_start_o = (state == C_READ);
  assign run_start_o = (state == C_CHECK) && sig_ok;
  assign write_start_o = (state == C_WRITE);
  assign halted_o = (state == C_HALT);
  assign spi_block_addr_o = autotest_pkg::BLOCK_BASE + blk_count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= C_READ;
      blk_count <= '0;
    end
    else
    begin
      case (state)
        C_READ:
          state <= C_READ_WAIT;
        C_READ_WAIT:
          if (read_done_i)
            state <= C_CHECK;
        C_CHECK:
          state <= sig_ok ? C_RUN_WAIT : C_HALT;
        C_RUN_WAIT:
          if (run_done_i)
            state <= C_WRITE;
        C_WRITE:
          state <= C_WRITE_WAIT;
        C_WRITE_WAIT:
          if (write_done_i)
          begin
            blk_count <= blk_count + 1'b1;
            state <= C_READ;
          end
        // only a reset leaves the halt after a bad signature
        C_HALT:
          state <= C_HALT;
        default:
          state <= C_HALT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/autotest_top.sv */
`timescale 1ns/1ps
`default_nettype none

module autotest_top (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    spi_busy_i,
  input  wire autotest_pkg::sd_byte_t   spi_data_out_i,
  input  wire logic                    end_uut_i,
  input  wire autotest_pkg::uut_block_t block_o_uut_i,
  output logic                         spi_rst_o,
  output logic                         spi_r_block_o,
  output logic                         spi_r_byte_o,
  output logic                         spi_w_block_o,
  output logic                         spi_w_byte_o,
  output autotest_pkg::sd_addr_t       spi_block_addr_o,
  output autotest_pkg::sd_byte_t       spi_data_in_o,
  output logic                         rst_uut_o,
  output autotest_pkg::uut_key_t       iv_uut_o,
  output autotest_pkg::uut_key_t       key_uut_o,
  output logic                         halted_o
);

  logic read_start;
  logic read_done;
  logic run_start;
  logic run_done;
  logic write_start;
  logic write_done;
  logic hdr_valid;
  autotest_pkg::sd_byte_t hdr_byte;
  autotest_pkg::signature_t signature;
  autotest_pkg::sd_byte_t iteration;
  autotest_pkg::uut_block_t result;

  autotest_ctrl i_autotest_ctrl (
    .clk              (clk),
    .rst              (rst),
    .read_done_i      (read_done),
    .run_done_i       (run_done),
    .write_done_i     (write_done),
    .signature_i      (signature),
    .read_start_o     (read_start),
    .run_start_o      (run_start),
    .write_start_o    (write_start),
    .spi_block_addr_o (spi_block_addr_o),
    .halted_o         (halted_o)
  );

  sd_block_reader i_sd_block_reader (
    .clk            (clk),
    .rst            (rst),
    .start_i        (read_start),
    .spi_busy_i     (spi_busy_i),
    .spi_data_out_i (spi_data_out_i),
    .spi_rst_o      (spi_rst_o),
    .spi_r_block_o  (spi_r_block_o),
    .spi_r_byte_o   (spi_r_byte_o),
    .hdr_valid_o    (hdr_valid),
    .hdr_byte_o     (hdr_byte),
    .done_o         (read_done)
  );

  // iv and key go straight to the uut
  test_vector_store i_test_vector_store (
    .clk         (clk),
    .rst         (rst),
    .clear_i     (read_start),
    .hdr_valid_i (hdr_valid),
    .hdr_byte_i  (hdr_byte),
    .signature_o (signature),
    .iteration_o (iteration),
    .iv_o        (iv_uut_o),
    .key_o       (key_uut_o)
  );

  uut_test_runner i_uut_test_runner (
    .clk       (clk),
    .rst       (rst),
    .start_i   (run_start),
    .end_uut_i (end_uut_i),
    .block_i   (block_o_uut_i),
    .rst_uut_o (rst_uut_o),
    .result_o  (result),
    .done_o    (run_done)
  );

  sd_block_writer i_sd_block_writer (
    .clk           (clk),
    .rst           (rst),
    .start_i       (write_start),
    .spi_busy_i    (spi_busy_i),
    .signature_i   (signature),
    .iteration_i   (iteration),
    .iv_i          (iv_uut_o),
    .key_i         (key_uut_o),
    .result_i      (result),
    .spi_w_block_o (spi_w_block_o),
    .spi_w_byte_o  (spi_w_byte_o),
    .spi_data_in_o (spi_data_in_o),
    .done_o        (write_done)
  );

endmodule

`default_nettype wire

/* tb/tb_sd_host_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sd_host_model #(
  parameter int NUM_BLOCKS = 4
) (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    spi_rst_i,
  input  wire logic                    spi_r_block_i,
  input  wire logic                    spi_r_byte_i,
  input  wire logic                    spi_w_block_i,
  input  wire logic                    spi_w_byte_i,
  input  wire autotest_pkg::sd_addr_t   spi_block_addr_i,
  input  wire autotest_pkg::sd_byte_t   spi_data_in_i,
  input  wire logic                    rst_uut_i,
  input  wire autotest_pkg::uut_key_t   iv_uut_i,
  input  wire autotest_pkg::uut_key_t   key_uut_i,
  output logic                         spi_busy_o,
  output autotest_pkg::sd_byte_t       spi_data_out_o,
  output logic                         end_uut_o,
  output autotest_pkg::uut_block_t     block_o_uut_o
);

  localparam int MEM_BYTES = NUM_BLOCKS * autotest_pkg::BLOCK_BYTES;

  // card contents as loaded by the testbench and as written back by the DUT
  autotest_pkg::sd_byte_t rd_mem [MEM_BYTES];
  autotest_pkg::sd_byte_t wr_mem [MEM_BYTES];
  int rd_count [NUM_BLOCKS];
  int wr_count [NUM_BLOCKS];
  autotest_pkg::sd_addr_t wr_opens [$];

  logic [31:0] seed = 32'h8c87;
  logic busy_q = 1'b0;
  autotest_pkg::sd_byte_t data_q = '0;
  logic end_q = 1'b0;
  autotest_pkg::uut_block_t block_q = '0;
  autotest_pkg::sd_byte_t iter_q = '0;
  int busy_left = 0;
  int blk = 0;
  int ptr = 0;
  int run_cnt = 0;
  logic rd_open = 1'b0;
  logic wr_open = 1'b0;

  assign spi_busy_o = busy_q;
  assign spi_data_out_o = data_q;
  assign end_uut_o = end_q;
  assign block_o_uut_o = block_q;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {16'h0, seed[30:15]};
  endfunction

  always @(posedge clk)
  begin : host_fsm
    int open_blk;
    open_blk = int'(spi_block_addr_i - autotest_pkg::BLOCK_BASE);
    if (rst)
    begin
      busy_q <= 1'b0;
      busy_left <= 0;
      rd_open <= 1'b0;
      wr_open <= 1'b0;
      for (int i = 0; i < NUM_BLOCKS; i++)
      begin
        rd_count[i] <= 0;
        wr_count[i] <= 0;
      end
      wr_opens.delete();
    end
    else
    begin
      if (!spi_r_block_i)
        rd_open <= 1'b0;
      if (!spi_w_block_i)
        wr_open <= 1'b0;
      if (busy_left > 0)
      begin
        busy_left <= busy_left - 1;
        if (busy_left == 1)
          busy_q <= 1'b0;
      end
      else if (spi_rst_i || (spi_r_block_i && !rd_open) || spi_r_byte_i ||
               (spi_w_block_i && !wr_open) || spi_w_byte_i)
      begin
        // every request gets 1 to 6 busy cycles
        busy_q <= 1'b1;
        busy_left <= 1 + int'(next_rand() % 32'd6);
        if (spi_r_block_i && !rd_open)
        begin
          rd_open <= 1'b1;
          blk <= open_blk;
          ptr <= 0;
          iter_q <= rd_mem[open_blk * autotest_pkg::BLOCK_BYTES + 4];
        end
        else if (spi_r_byte_i)
        begin
          data_q <= rd_mem[blk * autotest_pkg::BLOCK_BYTES + ptr];
          ptr <= ptr + 1;
          rd_count[blk] <= rd_count[blk] + 1;
        end
        else if (spi_w_block_i && !wr_open)
        begin
          wr_open <= 1'b1;
          blk <= open_blk;
          ptr <= 0;
          wr_opens.push_back(spi_block_addr_i);
        end
        else if (spi_w_byte_i)
        begin
          wr_mem[blk * autotest_pkg::BLOCK_BYTES + ptr] <= spi_data_in_i;
          ptr <= ptr + 1;
          wr_count[blk] <= wr_count[blk] + 1;
        end
      end
    end
  end

  // behavioral uut that never finishes on iteration 0xFF
  always @(posedge clk)
  begin
    block_q <= autotest_pkg::uut_block_t'(iv_uut_i ^ key_uut_i);
    if (rst_uut_i)
    begin
      run_cnt <= 0;
      end_q <= 1'b0;
    end
    else
    begin
      run_cnt <= run_cnt + 1;
      if (iter_q != 8'hFF && run_cnt == 4 * int'(iter_q) + 10)
        end_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* tb/tb_autotest.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_autotest;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 8;
  localparam int NUM_BLOCKS = 4;
  // blocks processed over all tests
  localparam int NUM_RUNS = 9;
  localparam int BLOCK_CYCLES =
    2 * autotest_pkg::BLOCK_BYTES * 10 + autotest_pkg::TIMEOUT_CYCLES + 100;
  localparam longint WATCHDOG_NS =
    longint'(NUM_RUNS * BLOCK_CYCLES + 4 * RESET_CYCLES) * CLK_PERIOD;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic spi_busy;
  autotest_pkg::sd_byte_t spi_data_out;
  logic end_uut;
  autotest_pkg::uut_block_t block_o_uut;
  logic spi_rst;
  logic spi_r_block;
  logic spi_r_byte;
  logic spi_w_block;
  logic spi_w_byte;
  autotest_pkg::sd_addr_t spi_block_addr;
  autotest_pkg::sd_byte_t spi_data_in;
  logic rst_uut;
  autotest_pkg::uut_key_t iv_uut;
  autotest_pkg::uut_key_t key_uut;
  logic halted;

  // what each block of the card was loaded with
  autotest_pkg::signature_t sig_tab [NUM_BLOCKS];
  autotest_pkg::sd_byte_t iter_tab [NUM_BLOCKS];
  autotest_pkg::uut_key_t iv_tab [NUM_BLOCKS];
  autotest_pkg::uut_key_t key_tab [NUM_BLOCKS];
  int run_len [NUM_BLOCKS];

  autotest_top i_autotest_top (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy),
    .spi_data_out_i   (spi_data_out),
    .end_uut_i        (end_uut),
    .block_o_uut_i    (block_o_uut),
    .spi_rst_o        (spi_rst),
    .spi_r_block_o    (spi_r_block),
    .spi_r_byte_o     (spi_r_byte),
    .spi_w_block_o    (spi_w_block),
    .spi_w_byte_o     (spi_w_byte),
    .spi_block_addr_o (spi_block_addr),
    .spi_data_in_o    (spi_data_in),
    .rst_uut_o        (rst_uut),
    .iv_uut_o         (iv_uut),
    .key_uut_o        (key_uut),
    .halted_o         (halted)
  );

  tb_sd_host_model #(.NUM_BLOCKS(NUM_BLOCKS)) i_host (
    .clk              (clk),
    .rst              (rst),
    .spi_rst_i        (spi_rst),
    .spi_r_block_i    (spi_r_block),
    .spi_r_byte_i     (spi_r_byte),
    .spi_w_block_i    (spi_w_block),
    .spi_w_byte_i     (spi_w_byte),
    .spi_block_addr_i (spi_block_addr),
    .spi_data_in_i    (spi_data_in),
    .rst_uut_i        (rst_uut),
    .iv_uut_i         (iv_uut),
    .key_uut_i        (key_uut),
    .spi_busy_o       (spi_busy),
    .spi_data_out_o   (spi_data_out),
    .end_uut_o        (end_uut),
    .block_o_uut_o    (block_o_uut)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the sequencer halted at %0t", $time);
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  task automatic check_byte(string name, autotest_pkg::sd_byte_t got,
                            autotest_pkg::sd_byte_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, autotest_pkg::sd_addr_t got,
                            autotest_pkg::sd_addr_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_block(string name, autotest_pkg::uut_block_t got,
                             autotest_pkg::uut_block_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_key(string name, autotest_pkg::uut_key_t got,
                           autotest_pkg::uut_key_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp)
    begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  // signature, iteration, iv and key in header order with each field msb first
  function automatic autotest_pkg::sd_byte_t header_byte(int blk, int i);
    logic [8*autotest_pkg::HEADER_BYTES-1:0] hdr;
    hdr = {sig_tab[blk], iter_tab[blk], iv_tab[blk], key_tab[blk]};
    return hdr[8*(autotest_pkg::HEADER_BYTES-1-i) +: 8];
  endfunction

  task automatic load_block(int blk, autotest_pkg::signature_t sig,
                            autotest_pkg::sd_byte_t iter, autotest_pkg::uut_key_t iv,
                            autotest_pkg::uut_key_t key);
    int idx;
    sig_tab[blk] = sig;
    iter_tab[blk] = iter;
    iv_tab[blk] = iv;
    key_tab[blk] = key;
    for (int i = 0; i < autotest_pkg::BLOCK_BYTES; i++)
    begin
      idx = blk * autotest_pkg::BLOCK_BYTES + i;
      if (i < autotest_pkg::HEADER_BYTES)
        i_host.rd_mem[idx] = header_byte(blk, i);
      else
        i_host.rd_mem[idx] = autotest_pkg::sd_byte_t'(idx ^ (idx >> 7));
    end
  endtask

  // the release edge in run_sequencer is the last reset cycle
  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (RESET_CYCLES - 1) @(posedge clk);
  endtask

  // releases reset and watches the DUT until it halts at bad_blk
  task automatic run_sequencer(int bad_blk);
    int blk;
    for (int i = 0; i < NUM_BLOCKS; i++)
      run_len[i] = 0;
    @(posedge clk);
    rst <= 1'b0;
    do
    begin
      @(negedge clk);
      blk = int'(spi_block_addr - autotest_pkg::BLOCK_BASE);
      if (!rst_uut)
      begin
        run_len[blk]++;
        check_key("iv_uut_o", iv_uut, iv_tab[blk]);
        check_key("key_uut_o", key_uut, key_tab[blk]);
      end
      if (!rst_uut && (spi_rst || spi_r_block || spi_r_byte || spi_w_block || spi_w_byte))
      begin
        $display("rst_uut_o is low while an SPI strobe is active at %0t", $time);
        abort_run();
      end
    end
    while (!halted);
    if (!rst_uut)
    begin
      $display("rst_uut_o is low after the sequencer halted");
      abort_run();
    end
    check_addr("spi_block_addr_o at halt", spi_block_addr,
               autotest_pkg::BLOCK_BASE + autotest_pkg::sd_addr_t'(bad_blk));
    check_count("write opens", i_host.wr_opens.size(), bad_blk);
    for (int k = 0; k < bad_blk; k++)
      check_addr("write address", i_host.wr_opens[k],
                 autotest_pkg::BLOCK_BASE + autotest_pkg::sd_addr_t'(k));
  endtask

  task automatic verify_block(int blk, bit good);
    int base;
    int exp_run;
    autotest_pkg::uut_block_t got;
    autotest_pkg::uut_block_t exp;
    base = blk * autotest_pkg::BLOCK_BYTES;
    check_count($sformatf("read handshakes block %0d", blk), i_host.rd_count[blk],
                autotest_pkg::BLOCK_BYTES);
    if (!good)
    begin
      check_count($sformatf("write handshakes block %0d", blk), i_host.wr_count[blk], 0);
      check_count($sformatf("run cycles block %0d", blk), run_len[blk], 0);
    end
    else
    begin
      // rst_uut_o rises two cycles after the model's run length or at the timeout
      if (iter_tab[blk] == 8'hFF)
        exp_run = autotest_pkg::TIMEOUT_CYCLES;
      else
        exp_run = 4 * int'(iter_tab[blk]) + 12;
      check_count($sformatf("run cycles block %0d", blk), run_len[blk], exp_run);
      check_count($sformatf("write handshakes block %0d", blk), i_host.wr_count[blk],
                  autotest_pkg::BLOCK_BYTES);
      for (int i = 0; i < autotest_pkg::HEADER_BYTES; i++)
        check_byte($sformatf("header byte %0d", i), i_host.wr_mem[base + i],
                   header_byte(blk, i));
      // result lsb first behind the header
      for (int k = 0; k < autotest_pkg::RESULT_BYTES; k++)
        got[8*k +: 8] = i_host.wr_mem[base + autotest_pkg::HEADER_BYTES + k];
      exp = autotest_pkg::uut_block_t'(iv_tab[blk] ^ key_tab[blk]);
      check_block($sformatf("result block %0d", blk), got, exp);
      for (int i = autotest_pkg::RECORD_BYTES; i < autotest_pkg::BLOCK_BYTES; i++)
        check_byte($sformatf("fill byte %0d", i), i_host.wr_mem[base + i],
                   autotest_pkg::FILL_BYTE);
    end
  endtask

  task automatic test_single_block();
    apply_reset();
    load_block(0, autotest_pkg::SIGNATURE_OK, 8'd3, 80'h0123_4567_89AB_CDEF_1357,
               80'hFEDC_BA98_7654_3210_2468);
    load_block(1, 32'hAABB_CCDE, 8'd1, 80'h1111_2222_3333_4444_5555,
               80'h6666_7777_8888_9999_AAAA);
    run_sequencer(1);
    verify_block(0, 1'b1);
    verify_block(1, 1'b0);
  endtask

  task automatic test_three_blocks();
    apply_reset();
    load_block(0, autotest_pkg::SIGNATURE_OK, 8'd0, 80'hA5A5_0000_1234_5678_9ABC,
               80'h5A5A_FFFF_0F0F_F0F0_3C3C);
    load_block(1, autotest_pkg::SIGNATURE_OK, 8'd1, 80'h0000_0000_0000_0000_0001,
               80'h8000_0000_0000_0000_0000);
    load_block(2, autotest_pkg::SIGNATURE_OK, 8'd5, 80'hDEAD_BEEF_CAFE_F00D_1234,
               80'h0BAD_C0DE_FACE_B00C_5678);
    load_block(3, 32'h0000_0000, 8'd2, 80'h0, 80'h0);
    run_sequencer(3);
    for (int b = 0; b < 3; b++)
      verify_block(b, 1'b1);
    verify_block(3, 1'b0);
  endtask

  task automatic test_timeout();
    apply_reset();
    load_block(0, autotest_pkg::SIGNATURE_OK, 8'hFF, 80'h1357_9BDF_0246_8ACE_1122,
               80'h3344_5566_7788_99AA_BBCC);
    load_block(1, autotest_pkg::SIGNATURE_OK, 8'd2, 80'hCAFE_0001_0002_0003_0004,
               80'h0005_0006_0007_0008_0009);
    load_block(2, 32'hDDCC_BBAA, 8'd0, 80'h1, 80'h2);
    run_sequencer(2);
    verify_block(0, 1'b1);
    verify_block(1, 1'b1);
    verify_block(2, 1'b0);
  endtask

  initial
  begin
    test_single_block();
    test_three_blocks();
    test_timeout();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
verilog/autotest_pkg.sv
verilog/sd_block_reader.sv
verilog/test_vector_store.sv
verilog/uut_test_runner.sv
verilog/sd_block_writer.sv
verilog/autotest_ctrl.sv
verilog/autotest_top.sv
tb/tb_sd_host_model.sv
tb/tb_autotest.sv

/* Makefile */
SIM := obj_dir/Vtb_autotest
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) filelist.f
	verilator --binary --top-module tb_autotest -f filelist.f -o Vtb_autotest

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
